/* rtl/uart_pkg.sv */
// Shared types, register map and frame states for the memory-mapped UART peripheral
package uart_pkg;

    // ----------------------------------------------------------------------
    // Data types
    // ----------------------------------------------------------------------

    // Processor data or address word
    typedef logic [31:0] io_word_t;

    // Serial payload
    typedef logic [7:0] uart_byte_t;

    // Data bits per 8N1 frame
    localparam int UART_DATA_BITS = 8;

    // ----------------------------------------------------------------------
    // Register map
    // ----------------------------------------------------------------------

    localparam io_word_t IO_STATUS_ADDR = 32'h8000_0000;
    localparam io_word_t IO_RX_ADDR     = 32'h8000_0004;
    localparam io_word_t IO_TX_ADDR     = 32'h8000_0008;

    // Status word bit positions
    localparam int STATUS_TX_READY_BIT = 0;
    localparam int STATUS_RX_VALID_BIT = 1;

    // ----------------------------------------------------------------------
    // Frame state machine
    // ----------------------------------------------------------------------

    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_e;

endpackage

/* rtl/uart_tx.sv */
// UART transmitter that shifts one byte out as an 8N1 frame behind a valid/ready input
module uart_tx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic                clock,
    input  logic                rst,
    input  uart_pkg::uart_byte_t tx_data,
    input  logic                tx_valid,
    output logic                tx_ready,
    output logic                serial_out
);

    import uart_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

    uart_state_e state;
    logic [CNT_W-1:0] bit_count;
    logic [2:0] bit_index;
    uart_byte_t shift_reg;
    logic bit_done;

    // Last clock of the current serial bit
    assign bit_done = (bit_count == CNT_W'(CLKS_PER_BIT - 1));

    // Busy from acceptance until the stop bit has been held in full
    assign tx_ready = (state == UART_IDLE);

    // ----------------------------------------------------------------------
    // Frame control
    // ----------------------------------------------------------------------

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            state      <= UART_IDLE;
            bit_count  <= '0;
            bit_index  <= '0;
            serial_out <= 1'b1;
        end
        else
        begin
            bit_count <= bit_done ? '0 : bit_count + 1'b1;
            case (state)
                UART_IDLE:
                begin
                    bit_count <= '0;
                    if (tx_valid)
                    begin
                        state      <= UART_START;
                        serial_out <= 1'b0;
                    end
                end
                UART_START:
                begin
                    if (bit_done)
                    begin
                        state      <= UART_DATA;
                        bit_index  <= '0;
                        serial_out <= shift_reg[0];
                    end
                end
                UART_DATA:
                begin
                    if (bit_done)
                    begin
                        if (bit_index == 3'(UART_DATA_BITS - 1))
                        begin
                            state      <= UART_STOP;
                            serial_out <= 1'b1;
                        end
                        else
                        begin
                            bit_index  <= bit_index + 1'b1;
                            // Next bit is already one place down after the shift
                            serial_out <= shift_reg[1];
                        end
                    end
                end
                default:
                begin
                    if (bit_done)
                    begin
                        state <= UART_IDLE;
                    end
                end
            endcase
        end
    end

    // LSB first
    always_ff @(posedge clock)
    begin
        if (state == UART_IDLE && tx_valid)
        begin
            shift_reg <= tx_data;
        end
        else if (state == UART_DATA && bit_done)
        begin
            shift_reg <= {1'b0, shift_reg[7:1]};
        end
    end

endmodule

/* rtl/uart_rx.sv */
// UART receiver that synchronizes the line, samples 8N1 frames at mid-bit and strobes out bytes
module uart_rx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic                 clock,
    input  logic                 rst,
    input  logic                 serial_in,
    output uart_pkg::uart_byte_t rx_byte,
    output logic                 rx_strobe
);

    import uart_pkg::*;

    localparam int CNT_W    = $clog2(CLKS_PER_BIT + 1);
    localparam int HALF_BIT = CLKS_PER_BIT / 2;

    logic sync_0;
    logic sync_1;
    uart_state_e state;
    logic [CNT_W-1:0] bit_count;
    logic [2:0] bit_index;
    uart_byte_t shift_reg;
    logic bit_done;
    logic half_done;

    assign bit_done  = (bit_count == CNT_W'(CLKS_PER_BIT - 1));
    assign half_done = (bit_count == CNT_W'(HALF_BIT - 1));
    assign rx_byte   = shift_reg;

    // ----------------------------------------------------------------------
    // Line synchronizer
    // ----------------------------------------------------------------------

    // Idles high so a reset does not look like a start edge
    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            sync_0 <= 1'b1;
            sync_1 <= 1'b1;
        end
        else
        begin
            sync_0 <= serial_in;
            sync_1 <= sync_0;
        end
    end

    // ----------------------------------------------------------------------
    // Frame control
    // ----------------------------------------------------------------------

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            state     <= UART_IDLE;
            bit_count <= '0;
            bit_index <= '0;
            rx_strobe <= 1'b0;
        end
        else
        begin
            rx_strobe <= 1'b0;
            bit_count <= bit_done ? '0 : bit_count + 1'b1;
            case (state)
                UART_IDLE:
                begin
                    bit_count <= '0;
                    if (!sync_1)
                    begin
                        state <= UART_START;
                    end
                end
                UART_START:
                begin
                    // Half a bit in, the line must still be low
                    if (half_done)
                    begin
                        bit_count <= '0;
                        bit_index <= '0;
                        state     <= sync_1 ? UART_IDLE : UART_DATA;
                    end
                end
                UART_DATA:
                begin
                    if (bit_done)
                    begin
                        if (bit_index == 3'(UART_DATA_BITS - 1))
                        begin
                            state <= UART_STOP;
                        end
                        bit_index <= bit_index + 1'b1;
                    end
                end
                default:
                begin
                    if (bit_done)
                    begin
                        state <= UART_IDLE;
                        // A low stop bit is a framing error
                        rx_strobe <= sync_1;
                    end
                end
            endcase
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge clock)
    begin
        if (state == UART_DATA && bit_done)
        begin
            shift_reg <= {sync_1, shift_reg[7:1]};
        end
    end

endmodule

/* rtl/uart.sv */
// UART core with a one-byte receive holding buffer around the transmitter and receiver
module uart #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic                 clock,
    input  logic                 rst,
    input  uart_pkg::uart_byte_t tx_data,
    input  logic                 tx_valid,
    output logic                 tx_ready,
    output uart_pkg::uart_byte_t rx_data,
    output logic                 rx_valid,
    input  logic                 rx_ready,
    input  logic                 serial_in,
    output logic                 serial_out
);

    import uart_pkg::*;

    uart_byte_t rx_byte;
    logic rx_strobe;
    uart_byte_t rx_hold;
    logic rx_full;

    uart_tx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) i_uart_tx (
        .clock     (clock),
        .rst       (rst),
        .tx_data   (tx_data),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready),
        .serial_out(serial_out)
    );

    uart_rx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) i_uart_rx (
        .clock    (clock),
        .rst      (rst),
        .serial_in(serial_in),
        .rx_byte  (rx_byte),
        .rx_strobe(rx_strobe)
    );

    // ----------------------------------------------------------------------
    // Receive holding buffer
    // ----------------------------------------------------------------------

    // Drop-new on overrun keeps the held byte until it is read
    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            rx_full <= 1'b0;
        end
        else if (rx_full && rx_ready)
        begin
            rx_full <= 1'b0;
        end
        else if (rx_strobe)
        begin
            rx_full <= 1'b1;
        end
    end

    always_ff @(posedge clock)
    begin
        if (rx_strobe && !rx_full)
        begin
            rx_hold <= rx_byte;
        end
    end

    assign rx_valid = rx_full;
    assign rx_data  = rx_hold;

endmodule

/* rtl/io_interface.sv */
// Processor I/O decoder that maps loads and stores onto the UART registers
module io_interface #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic               clock,
    input  logic               rst,
    input  uart_pkg::io_word_t addr,
    input  uart_pkg::io_word_t wdata,
    input  logic [3:0]         write_mask,
    input  logic               read_en,
    output uart_pkg::io_word_t rdata,
    input  logic               serial_in,
    output logic               serial_out
);

    import uart_pkg::*;

    uart_byte_t tx_data;
    logic tx_valid;
    logic tx_ready;
    uart_byte_t rx_data;
    logic rx_valid;
    logic rx_ready;
    logic store;
    logic load;

    uart #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) i_uart (
        .clock     (clock),
        .rst       (rst),
        .tx_data   (tx_data),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .rx_ready  (rx_ready),
        .serial_in (serial_in),
        .serial_out(serial_out)
    );

    // ----------------------------------------------------------------------
    // Address decode
    // ----------------------------------------------------------------------

    // Only byte lane 0 matters for the transmit register
    assign store = write_mask[0];
    assign load  = read_en;

    // The UART drops the byte itself if the transmitter is busy
    assign tx_valid = store && (addr == IO_TX_ADDR);
    assign tx_data  = wdata[7:0];

    // Reading the receive register consumes the held byte
    assign rx_ready = load && (addr == IO_RX_ADDR);

    // ----------------------------------------------------------------------
    // Read data
    // ----------------------------------------------------------------------

    always_comb
    begin
        rdata = '0;
        if (load)
        begin
            case (addr)
                IO_STATUS_ADDR:
                begin
                    rdata[STATUS_TX_READY_BIT] = tx_ready;
                    rdata[STATUS_RX_VALID_BIT] = rx_valid;
                end
                IO_RX_ADDR:
                begin
                    rdata = {24'b0, rx_data};
                end
                default:
                begin
                    rdata = '0;
                end
            endcase
        end
    end

endmodule

/* rtl/io_top.sv */
// Top level of the serial I/O peripheral joining the processor port and the UART pins
module io_top #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic               clock,
    input  logic               rst,
    input  uart_pkg::io_word_t addr,
    input  uart_pkg::io_word_t wdata,
    input  logic [3:0]         write_mask,
    input  logic               read_en,
    output uart_pkg::io_word_t rdata,
    input  logic               serial_in,
    output logic               serial_out
);

    // ----------------------------------------------------------------------
    // I/O decoder with the UART below it
    // ----------------------------------------------------------------------

    io_interface #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) i_io_interface (
        .clock     (clock),
        .rst       (rst),
        .addr      (addr),
        .wdata     (wdata),
        .write_mask(write_mask),
        .read_en   (read_en),
        .rdata     (rdata),
        .serial_in (serial_in),
        .serial_out(serial_out)
    );

endmodule

/* verification/io_tb.sv */
// Random-stimulus testbench for the serial I/O peripheral with a serial line model
module io_tb;

    import uart_pkg::*;

    localparam int CLKS_PER_BIT   = 8;
    localparam int FRAME_CYCLES   = 10 * CLKS_PER_BIT;
    localparam int NUM_TESTS      = 6;
    localparam int TIMEOUT_CYCLES = 20 * FRAME_CYCLES * NUM_TESTS + 1000;
    localparam int POLL_LIMIT     = 4 * FRAME_CYCLES;
    localparam io_word_t UNMAPPED_ADDR = 32'h8000_000C;

    logic clock;
    logic rst;
    io_word_t addr;
    io_word_t wdata;
    logic [3:0] write_mask;
    logic read_en;
    io_word_t rdata;
    logic serial_in;
    logic serial_out;

    int seed = 63668;
    int error_count = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int cycle_count = 0;

    // Bytes decoded from serial_out by the line monitor
    uart_byte_t tx_seen[$];
    // Bytes the model expects on serial_out
    uart_byte_t tx_expected[$];

    io_top #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) i_io_top (
        .clock     (clock),
        .rst       (rst),
        .addr      (addr),
        .wdata     (wdata),
        .write_mask(write_mask),
        .read_en   (read_en),
        .rdata     (rdata),
        .serial_in (serial_in),
        .serial_out(serial_out)
    );

    always #10 clock = ~clock;

    always @(posedge clock)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Simulation timed out after %0d clock cycles", cycle_count);
            $display("Finished with errors");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    // Compare tasks
    // ----------------------------------------------------------------------

    task automatic check_word(input string name, input io_word_t exp, input io_word_t act);
        if (act !== exp)
        begin
            $display("FAIL %s expected %h got %h", name, exp, act);
            error_count++;
        end
    endtask

    task automatic check_byte(input string name, input uart_byte_t exp, input uart_byte_t act);
        if (act !== exp)
        begin
            $display("FAIL %s expected %h got %h", name, exp, act);
            error_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("FAIL %s expected %h got %h", name, exp, act);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before)
        begin
            $display("%s: ok", name);
        end
        else
        begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    // ----------------------------------------------------------------------
    // Processor port
    // ----------------------------------------------------------------------

    // One-cycle load with rdata sampled on the falling edge
    task automatic load_word(input io_word_t a, input logic en, output io_word_t data);
        @(posedge clock);
        addr    <= a;
        read_en <= en;
        @(negedge clock);
        data = rdata;
        @(posedge clock);
        read_en <= 1'b0;
    endtask

    task automatic store_word(input io_word_t a, input io_word_t data);
        @(posedge clock);
        addr       <= a;
        wdata      <= data;
        write_mask <= 4'hf;
        @(posedge clock);
        write_mask <= 4'h0;
    endtask

    task automatic wait_status(input int bit_pos, input logic level);
        io_word_t data;
        int polls;
        polls = 0;
        load_word(IO_STATUS_ADDR, 1'b1, data);
        while (data[bit_pos] !== level && polls < POLL_LIMIT)
        begin
            load_word(IO_STATUS_ADDR, 1'b1, data);
            polls++;
        end
        if (data[bit_pos] !== level)
        begin
            $display("Status bit %0d never reached %0d while polling", bit_pos, level);
            error_count++;
        end
    endtask

    // ----------------------------------------------------------------------
    // Serial line model
    // ----------------------------------------------------------------------

    task automatic send_frame(input uart_byte_t data, input logic stop_level);
        logic [9:0] frame;
        frame = {stop_level, data, 1'b0};
        for (int i = 0; i < 10; i++)
        begin
            @(posedge clock);
            serial_in <= frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clock);
        end
        // Back to idle after a bad stop bit
        @(posedge clock);
        serial_in <= 1'b1;
    endtask

    task automatic capture_frame();
        uart_byte_t data;
        @(negedge clock);
        while (serial_out !== 1'b0)
        begin
            @(negedge clock);
        end
        // Middle of the start bit
        repeat (CLKS_PER_BIT / 2 - 1) @(negedge clock);
        check_bit("serial_out start bit", 1'b0, serial_out);
        for (int i = 0; i < 8; i++)
        begin
            repeat (CLKS_PER_BIT) @(negedge clock);
            data[i] = serial_out;
        end
        repeat (CLKS_PER_BIT) @(negedge clock);
        check_bit("serial_out stop bit", 1'b1, serial_out);
        tx_seen.push_back(data);
    endtask

    initial
    begin
        @(negedge clock);
        while (rst)
        begin
            @(negedge clock);
        end
        forever capture_frame();
    end

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------

    initial
    begin
        io_word_t data;
        uart_byte_t b;
        uart_byte_t first;
        int errors_before;
        logic rx_seen_high;

        clock      = 1'b0;
        rst        = 1'b1;
        addr       = '0;
        wdata      = '0;
        write_mask = 4'h0;
        read_en    = 1'b0;
        serial_in  = 1'b1;
        repeat (10) @(posedge clock);
        rst <= 1'b0;

        // Reset values and read decode
        errors_before = error_count;
        load_word(IO_STATUS_ADDR, 1'b1, data);
        check_word("rdata status after reset", 32'h1, data);
        check_bit("serial_out after reset", 1'b1, serial_out);
        load_word(UNMAPPED_ADDR, 1'b1, data);
        check_word("rdata unmapped", 32'h0, data);
        load_word(IO_STATUS_ADDR, 1'b0, data);
        check_word("rdata read_en low", 32'h0, data);
        report_test("test 1 reset and decode", errors_before);

        // Random transmit bytes
        errors_before = error_count;
        tx_seen.delete();
        tx_expected.delete();
        for (int i = 0; i < 20; i++)
        begin
            b = uart_byte_t'($random(seed));
            wait_status(STATUS_TX_READY_BIT, 1'b1);
            store_word(IO_TX_ADDR, {24'h0, b});
            tx_expected.push_back(b);
        end
        wait_status(STATUS_TX_READY_BIT, 1'b1);
        if (tx_seen.size() != tx_expected.size())
        begin
            $display("Saw %0d frames on serial_out but stored %0d bytes",
                     tx_seen.size(), tx_expected.size());
            error_count++;
        end
        while (tx_seen.size() > 0 && tx_expected.size() > 0)
        begin
            check_byte("serial_out frame", tx_expected.pop_front(), tx_seen.pop_front());
        end
        report_test("test 2 transmit", errors_before);

        // Store while busy is dropped
        errors_before = error_count;
        tx_seen.delete();
        first = uart_byte_t'($random(seed));
        wait_status(STATUS_TX_READY_BIT, 1'b1);
        store_word(IO_TX_ADDR, {24'h0, first});
        load_word(IO_STATUS_ADDR, 1'b1, data);
        check_word("rdata status while busy", 32'h0, data);
        store_word(IO_TX_ADDR, {24'h0, ~first});
        wait_status(STATUS_TX_READY_BIT, 1'b1);
        repeat (FRAME_CYCLES) @(posedge clock);
        if (tx_seen.size() != 1)
        begin
            $display("Expected one frame on serial_out but saw %0d", tx_seen.size());
            error_count++;
        end
        if (tx_seen.size() > 0)
        begin
            check_byte("serial_out frame", first, tx_seen.pop_front());
        end
        report_test("test 3 transmit back-pressure", errors_before);

        // Random receive bytes
        errors_before = error_count;
        for (int i = 0; i < 20; i++)
        begin
            b = uart_byte_t'($random(seed));
            send_frame(b, 1'b1);
            wait_status(STATUS_RX_VALID_BIT, 1'b1);
            load_word(IO_RX_ADDR, 1'b1, data);
            check_word("rdata rx", {24'h0, b}, data);
            load_word(IO_STATUS_ADDR, 1'b1, data);
            check_word("rdata status after rx read", 32'h1, data);
        end
        report_test("test 4 receive", errors_before);

        // Overrun keeps the first byte
        errors_before = error_count;
        first = uart_byte_t'($random(seed));
        b     = uart_byte_t'($random(seed));
        // The two bytes must differ to tell which one was kept
        if (b == first)
        begin
            b = ~first;
        end
        send_frame(first, 1'b1);
        send_frame(b, 1'b1);
        wait_status(STATUS_RX_VALID_BIT, 1'b1);
        load_word(IO_RX_ADDR, 1'b1, data);
        check_word("rdata rx overrun", {24'h0, first}, data);
        load_word(IO_STATUS_ADDR, 1'b1, data);
        check_word("rdata status after overrun", 32'h1, data);
        report_test("test 5 receive overrun", errors_before);

        // Framing error leaves the buffer empty
        errors_before = error_count;
        rx_seen_high = 1'b0;
        send_frame(uart_byte_t'($random(seed)), 1'b0);
        for (int i = 0; i < FRAME_CYCLES; i++)
        begin
            load_word(IO_STATUS_ADDR, 1'b1, data);
            if (data[STATUS_RX_VALID_BIT])
            begin
                rx_seen_high = 1'b1;
            end
        end
        check_bit("status rx_valid after framing error", 1'b0, rx_seen_high);
        report_test("test 6 framing error", errors_before);

        $display("Tests run %0d, tests failed %0d, total errors %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0)
        begin
            $display("Finished with no errors");
        end
        else
        begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* vlog.f */
rtl/uart_pkg.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart.sv
rtl/io_interface.sv
rtl/io_top.sv
verification/io_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the serial I/O peripheral testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG="Finished with errors"

verilator --binary --timing -f vlog.f --top-module io_tb -o io_tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/io_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if [ ! -s "$LOG" ]; then
    echo "Simulation log is empty"
    exit 1
fi

if grep -q "$FAIL_MSG" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation passed"
exit 0
